// File: src/nnMacros.svh
`ifndef NN_MACROS_SVH
`define NN_MACROS_SVH

// ************************************************************
// layer geometry
// ************************************************************
`define NN_NEURONS 4
`define NN_INPUTS 15

// ************************************************************
// queue depths and credits
// ************************************************************
`define NN_CMD_DEPTH 4 // also the sender's starting credits
`define NN_RES_DEPTH 8
`define NN_VEC_CREDITS 2 // NN_RES_DEPTH / NN_NEURONS

// fixed-point output slice of the 32-bit sum
`define NN_FRAC_LO 13
`define NN_FRAC_HI 28

`endif

// File: src/nnPkg.sv
`include "nnMacros.svh"

package nnPkg;

	// ************************************************************
	// command stream
	// ************************************************************
	typedef enum logic [1:0]
	{
		opWeight = 2'd0,
		opBias = 2'd1,
		opFeature = 2'd2,
		opFire = 2'd3
	} nnOp_t;

	typedef struct packed
	{
		nnOp_t op;
		logic [1:0] neuron; // target neuron for weight/bias
		logic [3:0] index; // input slot for weight/feature
		logic [31:0] value;
	} cmdWord_t;

	// ************************************************************
	// result stream
	// ************************************************************
	typedef struct packed
	{
		logic [1:0] neuron;
		logic [15:0] activation;
	} resultWord_t;

	// ************************************************************
	// vectors passed between stages
	// ************************************************************
	typedef logic [`NN_INPUTS - 1:0][31:0] featureVec_t;

	typedef logic [`NN_NEURONS - 1:0][31:0] sumVec_t;

endpackage

// File: src/creditFifo.sv
module creditFifo #(
	parameter type payload_t = logic [7:0],
	parameter int depth = 4
) (
	input logic clk,
	input logic reset,
	input logic push,
	input payload_t pushData,
	input logic pop,
	output payload_t popData,
	output logic notEmpty,
	output logic credit
);

	payload_t mem [depth];
	logic [$clog2(depth) - 1:0] wrPtr;
	logic [$clog2(depth) - 1:0] rdPtr;
	logic [$clog2(depth):0] count;
	logic doPop;

	assign notEmpty = count != 0;
	assign doPop = pop && notEmpty;
	assign popData = mem[rdPtr];
	assign credit = doPop; // one slot handed back per pop

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			mem[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1; // depth is a power of two
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// the upstream credit count must keep pushes within the depth
	noOverflow: assert property (@(posedge clk) disable iff (reset)
		push |-> (count != depth))
		else $error("creditFifo push while full");

endmodule

// File: src/layerLinks.sv
// ************************************************************
// decode to execute
// ************************************************************
interface execLink import nnPkg::*; ();

	logic wrEn;
	logic wrBias; // bias when set, else weight
	logic [1:0] wrNeuron;
	logic [3:0] wrIndex;
	logic [31:0] wrValue;
	logic fire;
	featureVec_t features;

	modport decode (
		output wrEn, wrBias, wrNeuron, wrIndex, wrValue, fire, features
	);

	modport execute (
		input wrEn, wrBias, wrNeuron, wrIndex, wrValue, fire, features
	);

endinterface

// ************************************************************
// execute to result, with the vector credit going back
// ************************************************************
interface sumLink import nnPkg::*; ();

	logic sumValid;
	sumVec_t sums;
	logic vecCredit; // returned to decode

	modport source (
		output sumValid, sums
	);

	modport sink (
		input sumValid, sums,
		output vecCredit
	);

endinterface

// File: src/cmdDecode.sv
`include "nnMacros.svh"

module cmdDecode import nnPkg::*; (
	input logic clk,
	input logic reset,
	input logic cmdValid,
	input cmdWord_t cmd,
	output logic cmdCredit,
	execLink.decode exec,
	input logic vecCredit
);

	cmdWord_t head;
	logic headValid;
	logic popHead;
	logic issueFire;
	logic [$clog2(`NN_VEC_CREDITS + 1) - 1:0] vecCount;

	creditFifo #(
		.payload_t(cmdWord_t),
		.depth(`NN_CMD_DEPTH)
	) cmdQueue (
		.clk(clk),
		.reset(reset),
		.push(cmdValid),
		.pushData(cmd),
		.pop(popHead),
		.popData(head),
		.notEmpty(headValid),
		.credit(cmdCredit)
	);

	// a fire stays at the head until a vector credit is free
	assign popHead = headValid && (head.op != opFire || vecCount != 0);
	assign issueFire = popHead && head.op == opFire;

	// ************************************************************
	// control and feature registers
	// ************************************************************
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			exec.fire <= 1'b0;
			exec.wrEn <= 1'b0;
			exec.features <= '0;
			vecCount <= `NN_VEC_CREDITS;
		end
		else
		begin
			exec.fire <= issueFire; // features sampled next cycle
			exec.wrEn <= popHead && (head.op == opWeight || head.op == opBias);
			if (popHead && head.op == opFeature && head.index < `NN_INPUTS)
				exec.features[head.index] <= head.value;
			if (issueFire && !vecCredit)
				vecCount <= vecCount - 1'b1;
			else if (vecCredit && !issueFire)
				vecCount <= vecCount + 1'b1;
		end
	end

	// write payload, qualified by wrEn
	always_ff @(posedge clk)
	begin
		exec.wrBias <= head.op == opBias;
		exec.wrNeuron <= head.neuron;
		exec.wrIndex <= head.index;
		exec.wrValue <= head.value;
	end

	// each returned vector credit matches an earlier fire
	noExtraVecCredit: assert property (@(posedge clk) disable iff (reset)
		vecCredit |-> (vecCount != `NN_VEC_CREDITS))
		else $error("cmdDecode vector credit returned with the counter full");

endmodule

// File: src/neuronExecute.sv
`include "nnMacros.svh"

module neuronExecute import nnPkg::*; (
	input logic clk,
	input logic reset,
	execLink.execute exec,
	sumLink.source sum
);

	logic [31:0] weights [`NN_NEURONS][`NN_INPUTS];
	logic [31:0] biases [`NN_NEURONS];
	logic [31:0] products [`NN_NEURONS][`NN_INPUTS];
	logic [31:0] biasHold [`NN_NEURONS];
	logic p1Valid;
	sumVec_t nextSum;

	// ************************************************************
	// weight and bias store
	// ************************************************************
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int n = 0; n < `NN_NEURONS; n++)
			begin
				biases[n] <= '0;
				for (int i = 0; i < `NN_INPUTS; i++)
					weights[n][i] <= '0;
			end
		end
		else if (exec.wrEn)
		begin
			if (exec.wrBias)
				biases[exec.wrNeuron] <= exec.wrValue;
			else if (exec.wrIndex < `NN_INPUTS)
				weights[exec.wrNeuron][exec.wrIndex] <= exec.wrValue; // slot 15 ignored
		end
	end

	// ************************************************************
	// stage 1: products, wrapped to 32 bits
	// ************************************************************
	always_ff @(posedge clk)
	begin
		if (exec.fire)
		begin
			for (int n = 0; n < `NN_NEURONS; n++)
			begin
				biasHold[n] <= biases[n]; // snapshot with the weights
				for (int i = 0; i < `NN_INPUTS; i++)
					products[n][i] <= weights[n][i] * exec.features[i];
			end
		end
	end

	// stage 2 adder tree
	always_comb
	begin
		logic [31:0] acc;
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			acc = biasHold[n];
			for (int i = 0; i < `NN_INPUTS; i++)
				acc = acc + products[n][i]; // wraps like the reference
			nextSum[n] = acc;
		end
	end

	always_ff @(posedge clk)
	begin
		if (p1Valid)
			sum.sums <= nextSum;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			p1Valid <= 1'b0;
			sum.sumValid <= 1'b0;
		end
		else
		begin
			p1Valid <= exec.fire;
			sum.sumValid <= p1Valid; // fire + 2
		end
	end

endmodule

// File: src/resultStage.sv
`include "nnMacros.svh"

module resultStage import nnPkg::*; (
	input logic clk,
	input logic reset,
	sumLink.sink sum,
	input logic resCredit,
	output logic resValid,
	output resultWord_t res
);

	sumVec_t pendVec [`NN_VEC_CREDITS];
	logic [$clog2(`NN_VEC_CREDITS) - 1:0] pendWr;
	logic [$clog2(`NN_VEC_CREDITS) - 1:0] pendRd;
	logic [$clog2(`NN_VEC_CREDITS + 1) - 1:0] pendCount;
	logic [1:0] neuronIdx;
	logic pushing;
	logic lastNeuron;
	logic [31:0] curSum;
	resultWord_t pushWord;
	logic [15:0] outCredits; // consumer may grant ahead

	// ************************************************************
	// vector hold and serializer, at most one vector per credit
	// ************************************************************
	assign pushing = pendCount != 0;
	assign lastNeuron = neuronIdx == 2'(`NN_NEURONS - 1);
	assign curSum = pendVec[pendRd][neuronIdx];
	assign pushWord.neuron = neuronIdx;
	assign pushWord.activation = curSum[31] ? '0 : curSum[`NN_FRAC_HI:`NN_FRAC_LO]; // rectifier

	always_ff @(posedge clk)
	begin
		if (sum.sumValid)
			pendVec[pendWr] <= sum.sums;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pendWr <= '0;
			pendRd <= '0;
			pendCount <= '0;
			neuronIdx <= '0;
			outCredits <= '0;
		end
		else
		begin
			if (sum.sumValid)
				pendWr <= pendWr + 1'b1;
			if (pushing)
				neuronIdx <= neuronIdx + 1'b1;
			if (pushing && lastNeuron)
				pendRd <= pendRd + 1'b1;
			if (sum.sumValid && !(pushing && lastNeuron))
				pendCount <= pendCount + 1'b1;
			else if (!sum.sumValid && pushing && lastNeuron)
				pendCount <= pendCount - 1'b1;
			if (resCredit && !resValid)
				outCredits <= outCredits + 1'b1;
			else if (resValid && !resCredit)
				outCredits <= outCredits - 1'b1;
		end
	end

	// a word leaves only when a credit is held
	creditFifo #(
		.payload_t(resultWord_t),
		.depth(`NN_RES_DEPTH)
	) resQueue (
		.clk(clk),
		.reset(reset),
		.push(pushing),
		.pushData(pushWord),
		.pop(outCredits != 0),
		.popData(res),
		.notEmpty(),
		.credit(resValid)
	);

	// vector slot is free once neuron 3 has left
	assign sum.vecCredit = resValid && res.neuron == 2'(`NN_NEURONS - 1);

	// decode's vector credits keep the hold from overflowing
	noPendOverflow: assert property (@(posedge clk) disable iff (reset)
		sum.sumValid |-> (pendCount != `NN_VEC_CREDITS))
		else $error("resultStage vector arrived with the hold full");

endmodule

// File: src/nnLayer.sv
module nnLayer import nnPkg::*; (
	input logic clk,
	input logic reset,
	input logic cmdValid,
	input nnOp_t cmdOp,
	input logic [1:0] cmdNeuron,
	input logic [3:0] cmdIndex,
	input logic [31:0] cmdValue,
	output logic cmdCredit,
	output logic resValid,
	output logic [1:0] resNeuron,
	output logic [15:0] resActivation,
	input logic resCredit
);

	cmdWord_t cmdIn;
	resultWord_t resOut;
	logic resIssue;

	execLink execBus ();
	sumLink sumBus ();

	assign cmdIn = '{op: cmdOp, neuron: cmdNeuron, index: cmdIndex, value: cmdValue};

	// ************************************************************
	// decode, execute, result
	// ************************************************************
	cmdDecode decode0 (
		.clk(clk),
		.reset(reset),
		.cmdValid(cmdValid),
		.cmd(cmdIn),
		.cmdCredit(cmdCredit),
		.exec(execBus.decode),
		.vecCredit(sumBus.vecCredit)
	);

	neuronExecute execute0 (
		.clk(clk),
		.reset(reset),
		.exec(execBus.execute),
		.sum(sumBus.source)
	);

	resultStage result0 (
		.clk(clk),
		.reset(reset),
		.sum(sumBus.sink),
		.resCredit(resCredit),
		.resValid(resIssue),
		.res(resOut)
	);

	assign resValid = resIssue;
	assign resNeuron = resOut.neuron;
	assign resActivation = resOut.activation;

endmodule

// File: verif/nnTbChecks.svh
`ifndef NN_TB_CHECKS_SVH
`define NN_TB_CHECKS_SVH

// ************************************************************
// error counters and compare tasks
// ************************************************************
int errorCount = 0;
int testErrors = 0; // errors of the running test
bit timedOut = 1'b0;

task automatic compareResult(input string name, input resultWord_t exp, input resultWord_t act);
	if (exp !== act)
	begin
		$display("Mismatch in %s: expected neuron %0d activation %h, actual neuron %0d activation %h",
			name, exp.neuron, exp.activation, act.neuron, act.activation);
		testErrors++;
	end
endtask

task automatic compareCount(input string name, input int exp, input int act);
	if (exp != act)
	begin
		$display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
		testErrors++;
	end
endtask

// ************************************************************
// bounded waits
// ************************************************************
task automatic resultsArrive(input string name, input int n);
	int waited;
	waited = 0;
	while (gotQ.size() < n && waited < waitLimit)
	begin
		@(negedge clk);
		waited++;
	end
	if (gotQ.size() < n)
	begin
		$display("%s: only %0d of %0d results arrived before the timeout", name, gotQ.size(), n);
		testErrors++;
		timedOut = 1'b1;
	end
endtask

task automatic creditsReturn(input string name, input int n);
	int waited;
	waited = 0;
	while (cmdCredits < n && waited < waitLimit)
	begin
		@(negedge clk);
		waited++;
	end
	if (cmdCredits < n)
	begin
		$display("%s: command credits did not come back before the timeout", name);
		testErrors++;
		timedOut = 1'b1;
	end
endtask

// fixed observation window, nothing may come out
task automatic expectQuiet(input string name, input int cycles);
	bit seen;
	seen = 1'b0;
	for (int c = 0; c < cycles; c++)
	begin
		@(negedge clk);
		if (gotQ.size() != 0 && !seen)
		begin
			$display("%s: a result came out before any resCredit was given", name);
			testErrors++;
			seen = 1'b1;
		end
	end
endtask

task automatic checkResults(input string name, input int n);
	resultsArrive(name, n);
	if (!timedOut)
		for (int k = 0; k < n; k++)
			compareResult(name, expQ.pop_front(), gotQ.pop_front());
endtask

task automatic finishTest(input string name);
	testsRun++;
	if (testErrors == 0)
		$display("test %s passed", name);
	else
	begin
		$display("test %s failed with %0d errors", name, testErrors);
		testsFailed++;
	end
	errorCount += testErrors;
	testErrors = 0;
endtask

`endif

// File: verif/nnLayerTb.sv
`include "nnMacros.svh"

module nnLayerTb import nnPkg::*; ();

	logic clk;
	logic reset;
	logic cmdValid;
	nnOp_t cmdOp;
	logic [1:0] cmdNeuron;
	logic [3:0] cmdIndex;
	logic [31:0] cmdValue;
	logic cmdCredit;
	logic resValid;
	logic [1:0] resNeuron;
	logic [15:0] resActivation;
	logic resCredit;

	int cmdSent = 0;
	int cmdCredits = 0; // cmdCredit pulses seen
	int waitLimit = 2000;
	int testsRun = 0;
	int testsFailed = 0;
	resultWord_t gotQ [$];
	resultWord_t expQ [$];
	logic [31:0] lfsrState = 32'd97906;
	logic [31:0] mWeights [`NN_NEURONS][`NN_INPUTS];
	logic [31:0] mBiases [`NN_NEURONS];
	logic [31:0] mFeatures [`NN_INPUTS];

	`include "nnTbChecks.svh"

	nnLayer dut0 (
		.clk(clk),
		.reset(reset),
		.cmdValid(cmdValid),
		.cmdOp(cmdOp),
		.cmdNeuron(cmdNeuron),
		.cmdIndex(cmdIndex),
		.cmdValue(cmdValue),
		.cmdCredit(cmdCredit),
		.resValid(resValid),
		.resNeuron(resNeuron),
		.resActivation(resActivation),
		.resCredit(resCredit)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// outputs sampled like a flop
	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (cmdCredit)
				cmdCredits++;
			if (resValid)
				gotQ.push_back({resNeuron, resActivation});
		end
	end

	// 32-bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// ************************************************************
	// reference model and command sender
	// ************************************************************
	task automatic expectVector();
		logic [31:0] acc;
		resultWord_t w;
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			acc = mBiases[n];
			for (int i = 0; i < `NN_INPUTS; i++)
				acc = acc + mWeights[n][i] * mFeatures[i]; // 32-bit wrap
			w.neuron = 2'(n);
			w.activation = acc[31] ? 16'h0 : 16'(acc >> 13);
			expQ.push_back(w);
		end
	endtask

	task automatic sendCmd(input nnOp_t op, input logic [1:0] neuron, input logic [3:0] index,
			input logic [31:0] value);
		int waited;
		waited = 0;
		@(negedge clk);
		while (cmdSent - cmdCredits >= `NN_CMD_DEPTH && waited < waitLimit)
		begin
			cmdValid = 1'b0; // out of credits
			@(negedge clk);
			waited++;
		end
		if (cmdSent - cmdCredits >= `NN_CMD_DEPTH)
		begin
			$display("sender: no command credit came back before the timeout");
			testErrors++;
			timedOut = 1'b1;
			cmdValid = 1'b0;
		end
		else
		begin
			cmdValid = 1'b1;
			cmdOp = op;
			cmdNeuron = neuron;
			cmdIndex = index;
			cmdValue = value;
			cmdSent++;
		end
	endtask

	task automatic sendIdle();
		@(negedge clk);
		cmdValid = 1'b0;
	endtask

	task automatic writeWeight(input int n, input int i, input logic [31:0] v);
		sendCmd(opWeight, 2'(n), 4'(i), v);
		mWeights[n][i] = v;
	endtask

	task automatic writeBias(input int n, input logic [31:0] v);
		sendCmd(opBias, 2'(n), 4'd0, v);
		mBiases[n] = v;
	endtask

	task automatic writeFeature(input int i, input logic [31:0] v);
		sendCmd(opFeature, 2'd0, 4'(i), v);
		mFeatures[i] = v;
	endtask

	task automatic fireVector();
		sendCmd(opFire, 2'd0, 4'd0, 32'd0);
		expectVector(); // model state at the fire
	endtask

	task automatic grantCredits(input int n);
		for (int k = 0; k < n; k++)
		begin
			@(negedge clk);
			resCredit = 1'b1;
			@(negedge clk);
			resCredit = 1'b0;
		end
	endtask

	// ************************************************************
	// directed tests
	// ************************************************************
	task automatic singleVector();
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			writeWeight(n, 0, 32'(n + 1));
			writeWeight(n, 1, 32'(n + 2));
			writeWeight(n, 2, 32'd3);
			writeBias(n, 32'(n * 8192));
		end
		writeFeature(0, 32'h0000_2000);
		writeFeature(1, 32'h0000_4000);
		writeFeature(2, 32'h0001_0000);
		fireVector();
		sendIdle();
		expectQuiet("singleVector", 20);
		grantCredits(4);
		checkResults("singleVector", 4);
		finishTest("singleVector");
	endtask

	task automatic rectifierZeros();
		writeBias(0, 32'h0010_0000);
		writeBias(1, 32'hC000_0000); // drives the sum negative
		writeBias(2, 32'h0000_0000);
		writeBias(3, 32'h9000_0000);
		sendIdle();
		grantCredits(4);
		fireVector();
		sendIdle();
		checkResults("rectifierZeros", 4);
		finishTest("rectifierZeros");
	endtask

	task automatic randomLayer();
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			for (int i = 0; i < `NN_INPUTS; i++)
				writeWeight(n, i, takeBits(32));
			writeBias(n, takeBits(32));
		end
		sendIdle();
		grantCredits(20);
		for (int v = 0; v < 5; v++)
		begin
			for (int i = 0; i < `NN_INPUTS; i++)
				writeFeature(i, takeBits(32));
			fireVector();
		end
		sendIdle();
		checkResults("randomLayer", 20);
		finishTest("randomLayer");
	endtask

	task automatic backPressure();
		fireVector();
		writeFeature(0, takeBits(32));
		fireVector();
		writeFeature(1, takeBits(32));
		fireVector(); // stalls on vector credits
		sendIdle();
		expectQuiet("backPressure", 30);
		grantCredits(12);
		checkResults("backPressure", 12);
		creditsReturn("backPressure", cmdSent);
		compareCount("backPressure cmdCredit total", cmdSent, cmdCredits);
		finishTest("backPressure");
	endtask

	task automatic inFlightWrite();
		for (int i = 1; i < `NN_INPUTS; i++)
			writeWeight(0, i, 32'd0);
		writeBias(0, 32'd0);
		writeFeature(0, 32'h0000_4000);
		writeWeight(0, 0, 32'h0000_0100);
		sendIdle();
		grantCredits(8);
		fireVector();
		writeWeight(0, 0, 32'h0000_0300); // right behind the fire
		fireVector();
		sendIdle();
		checkResults("inFlightWrite", 8);
		finishTest("inFlightWrite");
	endtask

	initial
	begin
		cmdValid = 1'b0;
		cmdOp = opWeight;
		cmdNeuron = 2'd0;
		cmdIndex = 4'd0;
		cmdValue = 32'd0;
		resCredit = 1'b0;
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			mBiases[n] = '0;
			for (int i = 0; i < `NN_INPUTS; i++)
				mWeights[n][i] = '0;
		end
		for (int i = 0; i < `NN_INPUTS; i++)
			mFeatures[i] = '0;
		reset = 1'b1;
		repeat (2) @(negedge clk);
		reset = 1'b0;

		singleVector();
		if (!timedOut)
			rectifierZeros();
		if (!timedOut)
			randomLayer();
		if (!timedOut)
			backPressure();
		if (!timedOut)
			inFlightWrite();

		$display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0 && !timedOut)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: compile.f
+incdir+src
+incdir+verif
src/nnPkg.sv
src/creditFifo.sv
src/layerLinks.sv
src/cmdDecode.sv
src/neuronExecute.sv
src/resultStage.sv
src/nnLayer.sv
verif/nnLayerTb.sv

// File: run.sh
#!/bin/sh
# build and run the nnLayer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module nnLayerTb --Mdir obj_dir -o nnLayerSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/nnLayerSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
	exit 1
fi
exit 0
